// ==== build.f ====
src/Pdp8Pkg.sv
src/Sequencer.sv
src/ProgramCounter.sv
src/CoreMemory.sv
src/Accumulator.sv
src/Pdp8Cpu.sv
test/ClockGen.sv
test/Pdp8Tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the PDP-8 CPU testbench with Verilator.
# Works from any directory, all paths are taken from the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert -Wno-fatal --timescale 1ns/1ns \
    --top-module Pdp8Tb -Mdir obj_dir -f build.f; then
  echo "Verilator compile failed"
  exit 1
fi

if ! ./obj_dir/VPdp8Tb > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -qx "PASS: all tests" "$LOG"; then
  exit 0
else
  exit 1
fi

// ==== src/Accumulator.sv ====
/*
  AC and link with AND/TAD, group 1 and group 2 operate logic.
  Group 1 IAC carry complements the link. BSW swaps 6-bit halves.
  Group 3 words are ignored. skipTaken is valid only with skipQuery.
*/
`timescale 1ns/1ns
`default_nettype none

module Accumulator
  import Pdp8Pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  accCtl_t cmd,
  input  word_t   memData,
  input  instr_u  opWord,
  input  word_t   switches,
  output word_t   ac,
  output logic    link,
  output logic    skipTaken
);

  logic [7:0]        micro;
  logic              isGroup1;
  logic              isGroup2;
  logic [WordBits:0] tadSum;
  logic [WordBits:0] rotWord;
  logic [WordBits:0] iacSum;
  word_t             g1Ac;
  logic              g1Link;
  word_t             g2Ac;
  logic              anyCond;
  logic              skipCond;

  assign micro = opWord.opr.micro;
  assign isGroup1 = !opWord.opr.group;
  assign isGroup2 = opWord.opr.group && !micro[0];

  assign tadSum = {1'b0, ac} + {1'b0, memData};

  // Group 1: clear, complement, IAC, then rotate
  always_comb begin
    g1Ac = micro[7] ? '0 : ac;
    g1Link = micro[6] ? 1'b0 : link;
    if (micro[5]) begin
      g1Ac = ~g1Ac;
    end
    if (micro[4]) begin
      g1Link = ~g1Link;
    end
    iacSum = {1'b0, g1Ac} + 13'd1;
    if (micro[0]) begin
      g1Ac = iacSum[WordBits-1:0];
      g1Link = g1Link ^ iacSum[WordBits];
    end
    rotWord = {g1Link, g1Ac};
    // RAR, RAL, twice/BSW
    case (micro[3:1])
      3'b100: rotWord = {rotWord[0], rotWord[12:1]};
      3'b101: rotWord = {rotWord[1:0], rotWord[12:2]};
      3'b010: rotWord = {rotWord[11:0], rotWord[12]};
      3'b011: rotWord = {rotWord[10:0], rotWord[12:11]};
      3'b001: rotWord = {rotWord[12], rotWord[5:0], rotWord[11:6]};
      default: begin
        // No rotate, or RAR and RAL together
      end
    endcase
  end

  // Group 2 skip works on the AC before CLA
  assign anyCond = (micro[6] && ac[WordBits-1])
                   || (micro[5] && (ac == '0))
                   || (micro[4] && link);
  assign skipCond = anyCond ^ micro[3];
  assign skipTaken = cmd.skipQuery && isGroup2 && skipCond;

  always_comb begin
    g2Ac = micro[7] ? '0 : ac;
    if (micro[2]) begin
      g2Ac = g2Ac | switches;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ac <= '0;
      link <= 1'b0;
    end else if (cmd.loadAnd) begin
      ac <= ac & memData;
    end else if (cmd.loadTad) begin
      ac <= tadSum[WordBits-1:0];
      link <= link ^ tadSum[WordBits];
    end else if (cmd.clearAc) begin
      ac <= '0;
    end else if (cmd.doOperate) begin
      if (isGroup1) begin
        {link, ac} <= rotWord;
      end else if (isGroup2) begin
        ac <= g2Ac;
      end
    end
  end

  // Sequencer issues at most one AC update per cycle
  assert property (@(posedge clk) disable iff (rst)
    $onehot0({cmd.loadAnd, cmd.loadTad, cmd.clearAc, cmd.doOperate}));

endmodule

`default_nettype wire

// ==== src/CoreMemory.sv ====
/*
  4K word memory, one shared write port. CPU reads return one cycle late;
  panel reads are combinational. Content is not initialised.
*/
`timescale 1ns/1ns
`default_nettype none

module CoreMemory
  import Pdp8Pkg::*;
(
  input  logic  clk,
  input  addr_t cpuAddr,
  input  logic  cpuWrite,
  input  word_t cpuWdata,
  output word_t cpuRdata,
  input  addr_t panelAddr,
  input  logic  panelWrite,
  input  word_t panelWdata,
  output word_t panelRdata
);

  word_t mem [MemWords];
  addr_t wrAddr;
  word_t wrData;

  // Panel only writes while the CPU is halted
  assign wrAddr = cpuWrite ? cpuAddr : panelAddr;
  assign wrData = cpuWrite ? cpuWdata : panelWdata;

  always_ff @(posedge clk) begin
    if (cpuWrite || panelWrite) begin
      mem[wrAddr] <= wrData;
    end
    cpuRdata <= mem[cpuAddr];
  end

  assign panelRdata = mem[panelAddr];

  assert property (@(posedge clk) !(cpuWrite && panelWrite));

endmodule

`default_nettype wire

// ==== src/Pdp8Cpu.sv ====
/*
  PDP-8 CPU top level with a simple front-panel port.
  Deposit and loadStart are ignored while running. No IOT devices,
  interrupts or MQ. Memory starts uninitialised.
*/
`timescale 1ns/1ns
`default_nettype none

module Pdp8Cpu
  import Pdp8Pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  panel_t panel,
  input  word_t  switches,
  output word_t  examineData,
  output word_t  ac,
  output logic   link,
  output addr_t  pc,
  output logic   running
);

  instr_u  ir;
  instr_u  opWord;
  addr_t   memAddr;
  logic    memWrite;
  word_t   memWdata;
  word_t   memData;
  accCtl_t accCmd;
  pcCtl_t  seqPcCmd;
  pcCtl_t  pcCmd;
  logic    irLoad;
  logic    skipTaken;
  logic    panelWrite;

  // Instruction register
  always_ff @(posedge clk) begin
    if (irLoad) begin
      ir <= memData;
    end
  end

  // Operate acts in Decode, before IR holds the word
  assign opWord = irLoad ? instr_u'(memData) : ir;

  assign panelWrite = panel.deposit && !running;

  // Switch load of the PC comes only from the panel
  always_comb begin
    pcCmd = seqPcCmd;
    pcCmd.loadSwitches = panel.loadStart && !running;
  end

  Sequencer theSequencer (
    .clk(clk),
    .rst(rst),
    .run(panel.run),
    .ir(ir),
    .memData(memData),
    .pc(pc),
    .skipTaken(skipTaken),
    .memAddr(memAddr),
    .memWrite(memWrite),
    .memWdata(memWdata),
    .ac(ac),
    .accCmd(accCmd),
    .pcCmd(seqPcCmd),
    .irLoad(irLoad),
    .running(running)
  );

  ProgramCounter thePc (
    .clk(clk),
    .rst(rst),
    .cmd(pcCmd),
    .switches(switches),
    .pc(pc)
  );

  CoreMemory theMemory (
    .clk(clk),
    .cpuAddr(memAddr),
    .cpuWrite(memWrite),
    .cpuWdata(memWdata),
    .cpuRdata(memData),
    .panelAddr(panel.examineAddr),
    .panelWrite(panelWrite),
    .panelWdata(panel.depositData),
    .panelRdata(examineData)
  );

  Accumulator theAcc (
    .clk(clk),
    .rst(rst),
    .cmd(accCmd),
    .memData(memData),
    .opWord(opWord),
    .switches(switches),
    .ac(ac),
    .link(link),
    .skipTaken(skipTaken)
  );

endmodule

`default_nettype wire

// ==== src/Pdp8Pkg.sv ====
/*
  Shared types for the reduced PDP-8 CPU.
  Word and address are both 12 bits wide. Bit numbering is LSB = 0, so
  PDP-8 bit 0 (the MSB) is bit 11 here. IOT and group 3 encodings decode
  but do nothing.
*/
`default_nettype none

package Pdp8Pkg;

  localparam int WordBits = 12;
  localparam int MemWords = 4096;

  typedef logic [WordBits-1:0] word_t;
  typedef logic [WordBits-1:0] addr_t;

  typedef enum logic [2:0] {
    OpAnd = 3'o0,
    OpTad = 3'o1,
    OpIsz = 3'o2,
    OpDca = 3'o3,
    OpJms = 3'o4,
    OpJmp = 3'o5,
    OpIot = 3'o6,
    OpOpr = 3'o7
  } opcode_e;

  // Memory-reference view of an instruction word
  typedef struct packed {
    opcode_e    opcode;
    logic       indirect;
    logic       page;
    logic [6:0] offset;
  } memRef_t;

  // Operate view; micro[0] separates group 2 from group 3
  typedef struct packed {
    opcode_e    opcode;
    logic       group;
    logic [7:0] micro;
  } opr_t;

  typedef union packed {
    memRef_t memRef;
    opr_t    opr;
  } instr_u;

  typedef enum logic [2:0] {
    StIdle,
    StFetch,
    StDecode,
    StDefer,
    StExecRead,
    StExecWrite
  } majorState_e;

  typedef struct packed {
    logic loadAnd;
    logic loadTad;
    logic clearAc;
    logic doOperate;
    logic skipQuery;
  } accCtl_t;

  typedef struct packed {
    logic  increment;
    logic  skip;
    logic  loadAddr;
    logic  loadSwitches;
    addr_t target;
  } pcCtl_t;

  // Front panel strobes; deposit writes depositData at examineAddr
  typedef struct packed {
    logic  deposit;
    addr_t examineAddr;
    word_t depositData;
    logic  loadStart;
    logic  run;
  } panel_t;

endpackage

`default_nettype wire

// ==== src/ProgramCounter.sv ====
/*
  Program counter. Priority: switch load, address load, skip, increment.
  Skip adds two, so it replaces the normal increment. Wraps at 12 bits.
*/
`timescale 1ns/1ns
`default_nettype none

module ProgramCounter
  import Pdp8Pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  pcCtl_t cmd,
  input  word_t  switches,
  output addr_t  pc
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (cmd.loadSwitches) begin
      pc <= switches;
    end else if (cmd.loadAddr) begin
      pc <= cmd.target;
    end else if (cmd.skip) begin
      pc <= pc + 12'd2;
    end else if (cmd.increment) begin
      pc <= pc + 12'd1;
    end
  end

endmodule

`default_nettype wire

// ==== src/Sequencer.sv ====
/*
  Major-state sequencer. The PC still holds the fetch address in Decode,
  so the current page and skips are taken from it there. ISZ moves the PC
  only in ExecWrite. Only one level of indirection, no auto-index.
*/
`timescale 1ns/1ns
`default_nettype none

module Sequencer
  import Pdp8Pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    run,
  input  instr_u  ir,
  input  word_t   memData,
  input  addr_t   pc,
  input  logic    skipTaken,
  output addr_t   memAddr,
  output logic    memWrite,
  output word_t   memWdata,
  input  word_t   ac,
  output accCtl_t accCmd,
  output pcCtl_t  pcCmd,
  output logic    irLoad,
  output logic    running
);

  majorState_e state;
  majorState_e nextState;
  addr_t       eaReg;
  word_t       iszData;
  instr_u      decWord;
  addr_t       directEa;
  logic        isGroup2;
  logic        haltNow;

  // IR is loaded at the end of Decode, so Decode looks at the memory word
  assign decWord = (state == StDecode) ? instr_u'(memData) : ir;

  // Page zero or current page of the fetch address
  assign directEa = {decWord.memRef.page ? pc[11:7] : 5'd0, decWord.memRef.offset};

  assign isGroup2 = (decWord.opr.opcode == OpOpr) && decWord.opr.group
                    && !decWord.opr.micro[0];
  assign haltNow = isGroup2 && decWord.opr.micro[1];

  always_comb begin
    nextState = state;
    memAddr = pc;
    memWrite = 1'b0;
    memWdata = ac;
    accCmd = '0;
    pcCmd = '0;
    irLoad = 1'b0;

    case (state)
      StIdle: begin
        if (run) begin
          nextState = StFetch;
        end
      end

      StFetch: begin
        memAddr = pc;
        nextState = StDecode;
      end

      StDecode: begin
        irLoad = 1'b1;
        // Start the operand or pointer read right away
        memAddr = directEa;
        pcCmd.increment = 1'b1;
        nextState = StFetch;
        case (decWord.memRef.opcode)
          OpAnd, OpTad: begin
            nextState = decWord.memRef.indirect ? StDefer : StExecRead;
          end
          OpIsz: begin
            pcCmd.increment = 1'b0;
            nextState = decWord.memRef.indirect ? StDefer : StExecRead;
          end
          OpDca, OpJms: begin
            nextState = decWord.memRef.indirect ? StDefer : StExecWrite;
          end
          OpJmp: begin
            if (decWord.memRef.indirect) begin
              nextState = StDefer;
            end else begin
              pcCmd.loadAddr = 1'b1;
              pcCmd.target = directEa;
            end
          end
          OpOpr: begin
            accCmd.doOperate = 1'b1;
            if (isGroup2) begin
              accCmd.skipQuery = 1'b1;
              pcCmd.skip = skipTaken;
            end
            if (haltNow) begin
              nextState = StIdle;
            end
          end
          default: begin
            // IOT is a no-op here
          end
        endcase
      end

      StDefer: begin
        // Pointer word is on memData; use it as the operand address
        memAddr = memData;
        case (ir.memRef.opcode)
          OpJmp: begin
            pcCmd.loadAddr = 1'b1;
            pcCmd.target = memData;
            nextState = StFetch;
          end
          OpAnd, OpTad, OpIsz: nextState = StExecRead;
          default: nextState = StExecWrite;
        endcase
      end

      StExecRead: begin
        memAddr = eaReg;
        nextState = StFetch;
        case (ir.memRef.opcode)
          OpAnd: accCmd.loadAnd = 1'b1;
          OpTad: accCmd.loadTad = 1'b1;
          default: nextState = StExecWrite;
        endcase
      end

      StExecWrite: begin
        memAddr = eaReg;
        memWrite = 1'b1;
        nextState = StFetch;
        case (ir.memRef.opcode)
          OpIsz: begin
            memWdata = iszData;
            // PC not yet moved for ISZ, so a skip is plus two
            pcCmd.skip = (iszData == '0);
            pcCmd.increment = 1'b1;
          end
          OpJms: begin
            memWdata = pc;
            pcCmd.loadAddr = 1'b1;
            pcCmd.target = eaReg + 12'd1;
          end
          default: begin
            memWdata = ac;
            accCmd.clearAc = 1'b1;
          end
        endcase
      end

      default: nextState = StIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= StIdle;
      running <= 1'b0;
    end else begin
      state <= nextState;
      running <= (nextState != StIdle);
    end
  end

  // Effective address and ISZ result
  always_ff @(posedge clk) begin
    if (state == StDecode) begin
      eaReg <= directEa;
    end else if (state == StDefer) begin
      eaReg <= memData;
    end
    if (state == StExecRead) begin
      iszData <= memData + 12'd1;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    memWrite |-> !(state inside {StFetch, StDefer}));

  assert property (@(posedge clk) disable iff (rst)
    state inside {StIdle, StFetch, StDecode, StDefer, StExecRead, StExecWrite});

endmodule

`default_nettype wire

// ==== test/ClockGen.sv ====
/*
  Testbench clock and reset. 10 ns period, rst held high for the first
  10 rising edges and released just after the tenth.
*/
`timescale 1ns/1ns
`default_nettype none

module ClockGen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/Pdp8Tb.sv ====
/*
  Testbench for Pdp8Cpu. Records from test/cpuPatterns.mem run in order
  with no reset between them, so AC, link and memory carry over.
  Run from the project root so that the pattern file is found.
*/
`timescale 1ns/1ns
`default_nettype none

module Pdp8Tb
  import Pdp8Pkg::*;
();

  localparam int RecWords = 25;
  localparam int MaxRecords = 16;

  logic   clk;
  logic   rst;
  panel_t panel;
  word_t  switches;
  word_t  examineData;
  word_t  ac;
  logic   link;
  addr_t  pc;
  logic   running;

  word_t       patterns [0:MaxRecords*RecWords];
  int          numRecords;
  int          errors = 0;
  int          testsFailed = 0;
  int unsigned cycles = 0;
  int unsigned cycleLimit = 0;

  ClockGen clockGen0 (
    .clk(clk),
    .rst(rst)
  );

  Pdp8Cpu dut0 (
    .clk(clk),
    .rst(rst),
    .panel(panel),
    .switches(switches),
    .examineData(examineData),
    .ac(ac),
    .link(link),
    .pc(pc),
    .running(running)
  );

  // Ends a run where the CPU never halts
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycleLimit != 0 && cycles >= cycleLimit) begin
      $display("Timeout after %0d cycles, the CPU did not halt", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic string testName(input int num);
    case (num)
      1: return "TAD overflow";
      2: return "ISZ and DCA";
      3: return "subroutines";
      4: return "group 1 operate";
      5: return "group 2 skips";
      6: return "halt and restart";
      default: return "unknown";
    endcase
  endfunction

  task automatic checkWord(input string name, input string what, input word_t expected,
                           input word_t actual);
    if (actual !== expected) begin
      $display("Fail %s %s: expected %04o, actual %04o", name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic checkBit(input string name, input string what, input logic expected,
                          input logic actual);
    if (actual !== expected) begin
      $display("Fail %s %s: expected %b, actual %b", name, what, expected, actual);
      errors++;
    end
  endtask

  // Deposit, set the start address, run to the halt, then compare
  task automatic runRecord(input int base);
    int    num;
    addr_t start;
    word_t sw;
    int    count;
    int    errorsBefore;
    string name;
    num = int'(patterns[base]);
    start = patterns[base + 1];
    sw = patterns[base + 2];
    count = int'(patterns[base + 3]);
    errorsBefore = errors;
    name = $sformatf("test %0d (%s)", num, testName(num));

    // One word per clock
    for (int i = 0; i < count; i++) begin
      @(posedge clk);
      panel.deposit <= 1'b1;
      panel.examineAddr <= patterns[base + 9 + 2*i];
      panel.depositData <= patterns[base + 10 + 2*i];
    end
    @(posedge clk);
    panel.deposit <= 1'b0;
    switches <= start;
    panel.loadStart <= 1'b1;
    @(posedge clk);
    panel.loadStart <= 1'b0;
    switches <= sw;
    panel.run <= 1'b1;
    @(posedge clk);
    panel.run <= 1'b0;

    // running goes high on this edge and falls after HLT
    @(negedge clk);
    while (running) begin
      @(negedge clk);
    end

    @(posedge clk);
    panel.examineAddr <= patterns[base + 7];
    @(negedge clk);
    checkWord(name, "ac", patterns[base + 4], ac);
    checkBit(name, "link", patterns[base + 5][0], link);
    checkWord(name, "pc", patterns[base + 6], pc);
    checkWord(name, $sformatf("memory at %04o", patterns[base + 7]), patterns[base + 8],
              examineData);
    if (errors == errorsBefore) begin
      $display("%s passed", name);
    end else begin
      $display("%s failed", name);
      testsFailed++;
    end
  endtask

  initial begin
    int maxWords;
    panel = '0;
    switches = '0;
    $readmemh("test/cpuPatterns.mem", patterns);
    numRecords = int'(patterns[0]);
    if (numRecords == 0 || numRecords > MaxRecords) begin
      $display("Pattern file holds a bad record count of %0d", numRecords);
      errors++;
      numRecords = 0;
    end

    maxWords = 0;
    for (int r = 0; r < numRecords; r++) begin
      if (int'(patterns[1 + r*RecWords + 3]) > maxWords) begin
        maxWords = int'(patterns[1 + r*RecWords + 3]);
      end
    end
    // Deposits, about six cycles per program word, setup margin, reset
    cycleLimit = numRecords * (maxWords + 6*maxWords + 20) + 20;

    @(negedge rst);
    for (int r = 0; r < numRecords; r++) begin
      runRecord(1 + r*RecWords);
    end

    $display("%0d tests run, %0d passed, %0d failed", numRecords,
             numRecords - testsFailed, testsFailed);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/cpuPatterns.mem ====
// Record count first, then two lines per test record, all values in hex
// First line has test number, start, switches, word count, expected AC, link and PC
// It ends with the address to examine and the word expected there
// Second line has eight address and data pairs to deposit, and unused pairs are zero
007
// TAD overflow, AC 2761 and link 1
001 080 000 008 5F1 001 085 089 D63
080 EC0 081 288 082 089 083 28A 084 F02 088 FAC 089 D63 08A 8D1
// ISZ on 7777 skips a HLT, DCA stores 1234 at 0022
002 100 000 008 000 000 106 012 29C
100 EC0 101 410 102 F02 103 211 104 612 105 F02 010 FFF 011 29C
// JMS to the current page and to page zero, return by JMP I
003 180 000 008 001 000 183 018 182
180 888 181 818 182 F02 188 000 189 EC1 18A B88 018 000 019 B18
// CLA CLL CMA IAC, RAL, RTR, CML RAR, BSW
004 200 000 006 030 000 206 200 EE1
200 EE1 201 E04 202 E0A 203 E18 204 E02 205 F02 000 000 000 000
// SZA skips, SNL does not, OSR, SPA skips
005 280 00F 008 00F 000 288 286 F02
280 EC0 281 F20 282 F02 283 F10 284 F04 285 F48 286 F02 287 F02
// Halt early, then deposit 0123 and restart at 1402
006 300 000 005 000 000 302 308 005
300 EC0 301 F02 302 288 303 F02 308 005 000 000 000 000 000 000
006 302 000 001 053 000 304 308 053
308 053 000 000 000 000 000 000 000 000 000 000 000 000 000 000
